// File: logic/integraB_defines.svh
`ifndef INTEGRAB_DEFINES_SVH
`define INTEGRAB_DEFINES_SVH

// the board registers live in the &FE3x page and ignore A1 and A0
`define IB_REG_MASK       16'hFFFC
`define IB_REG_PAGE       16'hFE30
`define IB_REG_SHADOW     16'hFE34
`define IB_REG_RTC_ADDR   16'hFE38
`define IB_REG_RTC_DATA   16'hFE3C

// whole &FE30..&FE3F block, used to open the data buffer
`define IB_FE3X_MASK      16'hFFF0
`define IB_FE3X_BASE      16'hFE30

// flag positions in the byte written to &FE30..&FE33
`define IB_BIT_PRVEN      6
`define IB_BIT_MEMSEL     7

// flag positions in the byte written to &FE34..&FE37
`define IB_BIT_PRVS8      4
`define IB_BIT_PRVS4      5
`define IB_BIT_PRVS1      6
`define IB_BIT_SHEN       7

// decode windows, both ends inclusive
`define IB_SCREEN_LO      16'h3000
`define IB_SCREEN_HI      16'h7FFF
`define IB_PRV1_LO        16'h8000
`define IB_PRV1_HI        16'h83FF
`define IB_PRV4_LO        16'h8000
`define IB_PRV4_HI        16'h8FFF
`define IB_PRV8_LO        16'h9000
`define IB_PRV8_HI        16'hAFFF
`define IB_SWR_LO         16'h8000
`define IB_SWR_HI         16'hBFFF

`define IB_IN_RANGE(a, lo, hi) (((a) >= (lo)) && ((a) <= (hi)))

// banks 0..3 can come from the motherboard sockets instead of onboard RAM
`define IB_BEEB_BANKS     4
// lowest bank of the 10/11, 12/13, 14/15 RAM pairs that take writes
`define IB_FIRST_RAM_BANK 10

`endif

// File: logic/ibPkg.sv
`include "integraB_defines.svh"

package ibPkg;

	// CPU address bus as seen by the board
	typedef logic [15:0] addrT;

	// CPU data bus, only sampled on writes to &FE30..&FE37
	typedef logic [7:0] dataT;

	// sideways bank number latched from data bits 3:0
	typedef logic [3:0] romBankT;

	// one flag per sideways bank
	// bit n belongs to bank n, e.g. the write protect jumpers
	typedef logic [15:0] bankMaskT;

	// jumpers for banks 0..3, a set bit keeps the motherboard ROM in that slot
	typedef logic [`IB_BEEB_BANKS-1:0] beebSelT;

endpackage

// File: logic/ibInterfaces.sv
`timescale 1ns/100ps

// configuration held in the paging registers
// the register block owns it and the two decoders only look at it
interface memCfgIf;
	import ibPkg::*;

	// bank paged into &8000..&BFFF
	romBankT romBank;
	// private RAM enable and memory select from &FE30
	logic prvEn;
	logic memSel;
	// private window sizes and shadow enable from &FE34
	logic prvS8;
	logic prvS4;
	logic prvS1;
	logic shEn;

	modport regs (
		output romBank,
		output prvEn,
		output memSel,
		output prvS8,
		output prvS4,
		output prvS1,
		output shEn
	);

	// the address map only needs the private and shadow flags
	modport map (
		input prvEn,
		input memSel,
		input prvS8,
		input prvS4,
		input prvS1,
		input shEn
	);

	modport bank (
		input romBank
	);
endinterface

// region hits of the current bus cycle, passed from the address map to the bank decode
interface memMapIf;
	// shadow screen or private RAM is being accessed
	logic shadowSel;
	// private RAM window hit alone
	logic prvAct;
	// address in &8000..&BFFF
	logic swrAddr;
	// address in &FE30..&FE3F
	logic fe3x;

	modport dec (
		output shadowSel,
		output prvAct,
		output swrAddr,
		output fe3x
	);

	// consumer side, read by the bank decode
	modport user (
		input shadowSel,
		input prvAct,
		input swrAddr,
		input fe3x
	);
endinterface

// File: logic/pagingRegs.sv
`timescale 1ns/100ps
`include "integraB_defines.svh"

module pagingRegs (
	input logic phi2,
	input logic bbc_nRST,
	input logic rnw,
	input ibPkg::addrT address,
	input ibPkg::dataT data,
	memCfgIf.regs cfg
);
	import ibPkg::*;

	// write strobes for the two register groups
	logic pageWr;
	logic shadowWr;

	// A1 and A0 are not decoded so each register shows up four times
	assign pageWr = !rnw && ((address & `IB_REG_MASK) == `IB_REG_PAGE);
	assign shadowWr = !rnw && ((address & `IB_REG_MASK) == `IB_REG_SHADOW);

	// the host drives the data for a write through the whole cycle
	// so it is taken at the rising phi2 edge that closes it
	always_ff @(posedge phi2) begin
		if (!bbc_nRST) begin
			cfg.romBank <= '0;
			cfg.prvEn <= 1'b0;
			cfg.memSel <= 1'b0;
			cfg.prvS8 <= 1'b0;
			cfg.prvS4 <= 1'b0;
			cfg.prvS1 <= 1'b0;
			cfg.shEn <= 1'b0;
		end else begin
			// &FE30 holds the bank number, the private enable and memory select
			// bits 5 and 4 of this byte are not used by the board
			if (pageWr) begin
				cfg.romBank <= data[$bits(romBankT)-1:0];
				cfg.prvEn <= data[`IB_BIT_PRVEN];
				cfg.memSel <= data[`IB_BIT_MEMSEL];
			end
			// &FE34 holds the private window sizes and the shadow enable
			// its low nibble belongs to the host and is ignored here
			if (shadowWr) begin
				cfg.prvS8 <= data[`IB_BIT_PRVS8];
				cfg.prvS4 <= data[`IB_BIT_PRVS4];
				cfg.prvS1 <= data[`IB_BIT_PRVS1];
				cfg.shEn <= data[`IB_BIT_SHEN];
			end
		end
	end

	// after a reset edge the decoders must see an unpaged board
	// with bank 0, no shadow screen and no private RAM
	property cfgClearedAfterReset;
		@(posedge phi2) !bbc_nRST |=> (cfg.romBank == '0) && !cfg.prvEn && !cfg.memSel
			&& !cfg.prvS8 && !cfg.prvS4 && !cfg.prvS1 && !cfg.shEn;
	endproperty

	aCfgClearedAfterReset: assert property (cfgClearedAfterReset)
		else $error("paging configuration not cleared after reset");

endmodule

// File: logic/memoryMapDecoder.sv
`timescale 1ns/100ps
`include "integraB_defines.svh"

module memoryMapDecoder (
	input ibPkg::addrT address,
	input logic rnw,
	input logic phi1,
	memCfgIf.map cfg,
	memMapIf.dec map,
	output logic toBbcPhi1,
	output logic toBbcRnW,
	output logic rtcAs,
	output logic rtcDs
);
	import ibPkg::*;

	// raw address window hits
	logic inScreen;
	logic inPrv1;
	logic inPrv4;
	logic inPrv8;
	// qualified hits
	logic shHit;
	logic prvHit;
	// address with A1 and A0 dropped, for the register strobes
	addrT regAddr;

	assign inScreen = `IB_IN_RANGE(address, `IB_SCREEN_LO, `IB_SCREEN_HI);
	assign inPrv1 = `IB_IN_RANGE(address, `IB_PRV1_LO, `IB_PRV1_HI);
	assign inPrv4 = `IB_IN_RANGE(address, `IB_PRV4_LO, `IB_PRV4_HI);
	assign inPrv8 = `IB_IN_RANGE(address, `IB_PRV8_LO, `IB_PRV8_HI);

	// shadow screen replaces &3000..&7FFF unless memory select points the CPU
	// back at the main screen memory
	assign shHit = inScreen && cfg.shEn && !cfg.memSel;

	// the private windows share one 32k part with the shadow screen
	// S1 and S4 both start at &8000, S8 sits above them at &9000..&AFFF
	assign prvHit = cfg.prvEn && ((inPrv1 && cfg.prvS1) || (inPrv4 && cfg.prvS4)
		|| (inPrv8 && cfg.prvS8));

	assign map.shadowSel = shHit || prvHit;
	assign map.prvAct = prvHit;
	assign map.swrAddr = `IB_IN_RANGE(address, `IB_SWR_LO, `IB_SWR_HI);
	assign map.fe3x = (address & `IB_FE3X_MASK) == `IB_FE3X_BASE;

	// while the shadow screen is accessed the host sees a read in phi1
	// so the motherboard RAM keeps its contents and the video is left alone
	assign toBbcPhi1 = phi1 || shHit;
	assign toBbcRnW = rnw || shHit;

	// external RTC, the address strobe is write only
	// while the data strobe covers both directions
	assign regAddr = address & `IB_REG_MASK;
	assign rtcAs = !rnw && (regAddr == `IB_REG_RTC_ADDR);
	assign rtcDs = regAddr == `IB_REG_RTC_DATA;

endmodule

// File: logic/romBankDecoder.sv
`timescale 1ns/100ps
`include "integraB_defines.svh"

module romBankDecoder (
	input logic rnw,
	input ibPkg::bankMaskT writeProt,
	input ibPkg::beebSelT beebRomSel,
	memCfgIf.bank cfg,
	memMapIf.user map,
	output logic nRomBankSel0to3,
	output logic [3:0] nRomBankSel,
	output logic nWds,
	output logic nRds,
	output logic nDBufCe,
	output logic nDBufDir
);
	import ibPkg::*;

	// sideways access that is not claimed by private RAM
	logic romDec;
	// one-hot select of the paged bank, all zero outside sideways space
	bankMaskT bankSel;
	// paged bank is served by a motherboard ROM socket
	logic beebHit;
	// write to an unprotected onboard RAM bank
	logic ramWrHit;

	assign romDec = map.swrAddr && !map.prvAct;

	always_comb begin
		bankSel = '0;
		if (romDec) begin
			bankSel[cfg.romBank] = 1'b1;
		end
	end

	// a set jumper leaves banks 0..3 on the motherboard
	// a clear one moves the bank onto the board RAM
	assign beebHit = |(bankSel[`IB_BEEB_BANKS-1:0] & beebRomSel);
	assign nRomBankSel0to3 = !beebHit;

	// select 0 is the shared shadow and private RAM part
	assign nRomBankSel[0] = !map.shadowSel;

	// the remaining selects each cover an even/odd pair of banks
	// A14 of the RAM then picks the bank within the pair
	genvar pair;
	generate
		for (pair = 0; pair < 3; pair++) begin : gPairSel
			assign nRomBankSel[pair + 1] = !(|bankSel[`IB_FIRST_RAM_BANK + 2 * pair +: 2]);
		end
	endgenerate

	// only banks 10..15 take writes and each one has its own protect jumper
	assign ramWrHit = |(bankSel[15:`IB_FIRST_RAM_BANK] & ~writeProt[15:`IB_FIRST_RAM_BANK]);

	// the shadow RAM part is never protected
	assign nWds = !(!rnw && (ramWrHit || map.shadowSel));
	assign nRds = !rnw;

	// the board buffer opens for its own sideways banks, shadow, private RAM
	// and the register page, but stays shut when a motherboard ROM drives the bus
	assign nDBufCe = !((map.swrAddr && !beebHit) || map.shadowSel || map.fe3x);
	assign nDBufDir = rnw;

	// the pair selects come from one bank number and must never overlap
	// each settled value is checked when the selects move on
	aPairSelOneCold: assert property (@(nRomBankSel) $onehot0(~nRomBankSel[3:1]))
		else $error("more than one RAM pair selected");

endmodule

// File: logic/integraB.sv
`timescale 1ns/100ps

module integraB (
	input logic phi2,
	input logic bbc_nRST,
	input logic phi1,
	input logic rnw,
	input ibPkg::addrT address,
	input ibPkg::dataT data,
	input ibPkg::bankMaskT writeProt,
	input ibPkg::beebSelT beebRomSel,
	output logic toBbcPhi1,
	output logic toBbcRnW,
	output logic rtcAs,
	output logic rtcDs,
	output logic nRomBankSel0to3,
	output logic [3:0] nRomBankSel,
	output logic nWds,
	output logic nRds,
	output logic nDBufCe,
	output logic nDBufDir
);

	// register contents shared by both decoders
	memCfgIf cfgBus ();
	// region hits from the address map
	memMapIf mapBus ();

	// the only state on the board, written through &FE30..&FE37
	pagingRegs uPagingRegs (
		.phi2(phi2),
		.bbc_nRST(bbc_nRST),
		.rnw(rnw),
		.address(address),
		.data(data),
		.cfg(cfgBus)
	);

	// shadow, private and register page decode plus the RTC strobes
	memoryMapDecoder uMemoryMapDecoder (
		.address(address),
		.rnw(rnw),
		.phi1(phi1),
		.cfg(cfgBus),
		.map(mapBus),
		.toBbcPhi1(toBbcPhi1),
		.toBbcRnW(toBbcRnW),
		.rtcAs(rtcAs),
		.rtcDs(rtcDs)
	);

	// bank selects, strobes and buffer control for the current cycle
	romBankDecoder uRomBankDecoder (
		.rnw(rnw),
		.writeProt(writeProt),
		.beebRomSel(beebRomSel),
		.cfg(cfgBus),
		.map(mapBus),
		.nRomBankSel0to3(nRomBankSel0to3),
		.nRomBankSel(nRomBankSel),
		.nWds(nWds),
		.nRds(nRds),
		.nDBufCe(nDBufCe),
		.nDBufDir(nDBufDir)
	);

endmodule

// File: verif/ibClockGen.sv
`timescale 1ns/100ps

// phi2 bus clock with a 10 ns period, reset held low for the first 3 cycles
module ibClockGen (
	output logic phi2,
	output logic bbc_nRST
);

	initial begin
		phi2 = 1'b0;
		forever #5 phi2 = ~phi2;
	end

	// release on a falling edge so the DUT sees a clean level at the next rising edge
	initial begin
		bbc_nRST = 1'b0;
		repeat (3) @(posedge phi2);
		@(negedge phi2);
		bbc_nRST = 1'b1;
	end

endmodule

// File: verif/integraBTb.sv
`timescale 1ns/100ps

module integraBTb;
	import ibPkg::*;

	logic phi2;
	logic bbc_nRST;
	logic phi1;
	logic rnw;
	addrT address;
	dataT data;
	bankMaskT writeProt;
	beebSelT beebRomSel;
	logic toBbcPhi1;
	logic toBbcRnW;
	logic rtcAs;
	logic rtcDs;
	logic nRomBankSel0to3;
	logic [3:0] nRomBankSel;
	logic nWds;
	logic nRds;
	logic nDBufCe;
	logic nDBufDir;

	int errCount = 0;
	int testCount = 0;
	int failedTests = 0;
	logic [31:0] lfsr = 32'h8a05;
	logic resetReleased;

	ibClockGen clockGen (.phi2(phi2), .bbc_nRST(bbc_nRST));

	integraB uut (
		.phi2(phi2), .bbc_nRST(bbc_nRST), .phi1(phi1), .rnw(rnw),
		.address(address), .data(data), .writeProt(writeProt), .beebRomSel(beebRomSel),
		.toBbcPhi1(toBbcPhi1), .toBbcRnW(toBbcRnW), .rtcAs(rtcAs), .rtcDs(rtcDs),
		.nRomBankSel0to3(nRomBankSel0to3), .nRomBankSel(nRomBankSel),
		.nWds(nWds), .nRds(nRds), .nDBufCe(nDBufCe), .nDBufDir(nDBufDir)
	);

	// taps 32, 22, 2 and 1, new bit enters at the bottom
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic takeBit();
		lfsr = lfsrNext(lfsr);
		return lfsr[0];
	endfunction

	function automatic logic [15:0] takeBits(input int count);
		logic [15:0] bits;
		int i;
		bits = '0;
		for (i = 0; i < count; i++) begin
			bits = {bits[14:0], takeBit()};
		end
		return bits;
	endfunction

	// uniform enough over the small windows of the memory map
	function automatic addrT randIn(input addrT lo, input addrT hi);
		int span;
		span = int'(hi) - int'(lo) + 1;
		return addrT'(int'(lo) + (int'(takeBits(16)) % span));
	endfunction

	// the registers ignore A1 and A0 so any of the four aliases will do
	function automatic addrT withAlias(input addrT base);
		return base | takeBits(2);
	endfunction

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$finish;
	endtask

	task automatic checkBit(input string name, input logic got, input logic expv);
		assert (got === expv) else begin
			$display("FAIL t=%0t %s got %b expected %b", $time, name, got, expv);
			errCount++;
		end
	endtask

	task automatic checkNibble(input string name, input logic [3:0] got, input logic [3:0] expv);
		assert (got === expv) else begin
			$display("FAIL t=%0t %s got %b expected %b", $time, name, got, expv);
			errCount++;
		end
	endtask

	task automatic reportTest(input string name, input int errsBefore);
		testCount++;
		if (errCount == errsBefore) begin
			$display("test %s: ok", name);
		end else begin
			failedTests++;
			$display("test %s: %0d checks failed", name, errCount - errsBefore);
		end
	endtask

	// called on a falling edge, the outputs are sampled on the next one
	// where the bus cycle and any register update have both settled
	task automatic applyCycle(input addrT addr, input logic rw, input dataT d, input logic p1);
		address = addr;
		rnw = rw;
		data = d;
		phi1 = p1;
		@(negedge phi2);
	endtask

	task automatic writeReg(input addrT base, input dataT d);
		applyCycle(withAlias(base), 1'b0, d, 1'b0);
	endtask

	task automatic waitResetRelease(output logic released);
		int cycles;
		cycles = 0;
		while (bbc_nRST !== 1'b1 && cycles < 20) begin
			@(posedge phi2);
			cycles++;
		end
		released = (bbc_nRST === 1'b1);
		if (released) begin
			@(negedge phi2);
		end
	endtask

	task automatic testReset();
		int errsBefore;
		int i;
		addrT addr;
		logic rw;
		logic p1;
		errsBefore = errCount;
		for (i = 0; i < 24; i++) begin
			// low RAM or the OS and IO area, both outside every board region
			addr = takeBit() ? randIn(16'h0000, 16'h2FFF) : randIn(16'hC000, 16'hFDFF);
			rw = takeBit();
			p1 = takeBit();
			applyCycle(addr, rw, dataT'(takeBits(8)), p1);
			checkBit("nRomBankSel0to3", nRomBankSel0to3, 1'b1);
			checkNibble("nRomBankSel", nRomBankSel, 4'hF);
			checkBit("nWds", nWds, 1'b1);
			if (!rw) begin
				checkBit("nRds", nRds, 1'b1);
			end
			checkBit("nDBufCe", nDBufCe, 1'b1);
			checkBit("rtcAs", rtcAs, 1'b0);
			checkBit("rtcDs", rtcDs, 1'b0);
			checkBit("toBbcPhi1", toBbcPhi1, p1);
			checkBit("toBbcRnW", toBbcRnW, rw);
			checkBit("nDBufDir", nDBufDir, rw);
		end
		reportTest("reset", errsBefore);
	endtask

	task automatic testBankPaging();
		int errsBefore;
		int pass;
		int n;
		logic [3:0] bank;
		logic beebExp;
		logic [2:0] pairExp;
		errsBefore = errCount;
		for (pass = 0; pass < 2; pass++) begin
			// second pass inverts the jumpers so every bank sees both settings
			if (pass == 1) begin
				writeProt = ~writeProt;
				beebRomSel = ~beebRomSel;
			end
			for (n = 0; n < 16; n++) begin
				bank = 4'(n);
				beebExp = (bank < 4'd4) && beebRomSel[bank[1:0]];
				case (bank)
					4'd10, 4'd11: pairExp = 3'b110;
					4'd12, 4'd13: pairExp = 3'b101;
					4'd14, 4'd15: pairExp = 3'b011;
					default: pairExp = 3'b111;
				endcase
				writeReg(16'hFE30, {4'h0, bank});
				applyCycle(randIn(16'h8000, 16'hBFFF), 1'b1, 8'h00, 1'b0);
				checkBit("nRomBankSel0to3", nRomBankSel0to3, !beebExp);
				checkNibble("nRomBankSel", nRomBankSel, {pairExp, 1'b1});
				checkBit("nDBufCe", nDBufCe, beebExp);
				applyCycle(randIn(16'h8000, 16'hBFFF), 1'b0, dataT'(takeBits(8)), 1'b0);
				checkBit("nWds", nWds, !((bank >= 4'd10) && !writeProt[bank]));
			end
		end
		reportTest("bank paging", errsBefore);
	endtask

	task automatic testShadow();
		int errsBefore;
		int sel;
		int i;
		logic rw;
		errsBefore = errCount;
		writeReg(16'hFE34, 8'h80);
		for (sel = 0; sel < 2; sel++) begin
			// memory select hands the screen area back to main RAM
			writeReg(16'hFE30, (sel == 1) ? 8'h80 : 8'h00);
			for (i = 0; i < 8; i++) begin
				rw = takeBit();
				applyCycle(randIn(16'h3000, 16'h7FFF), rw, dataT'(takeBits(8)), 1'b0);
				checkBit("toBbcPhi1", toBbcPhi1, sel == 0);
				checkBit("toBbcRnW", toBbcRnW, (sel == 0) || rw);
				checkBit("nRomBankSel[0]", nRomBankSel[0], sel == 1);
				checkBit("nWds", nWds, (sel == 1) || rw);
			end
		end
		writeReg(16'hFE34, 8'h00);
		writeReg(16'hFE30, 8'h00);
		reportTest("shadow", errsBefore);
	endtask

	// bank 12 is paged so a ROM select that leaks through shows on pair 12/13
	task automatic checkWindow(input dataT sizeBits, input addrT inLo, input addrT inHi,
		input addrT outLo, input addrT outHi);
		int i;
		writeReg(16'hFE34, sizeBits);
		for (i = 0; i < 6; i++) begin
			applyCycle(randIn(inLo, inHi), takeBit(), 8'h00, 1'b0);
			checkNibble("nRomBankSel", nRomBankSel, 4'b1110);
			checkBit("nRomBankSel0to3", nRomBankSel0to3, 1'b1);
			applyCycle(randIn(outLo, outHi), 1'b1, 8'h00, 1'b0);
			checkNibble("nRomBankSel", nRomBankSel, 4'b1011);
		end
	endtask

	task automatic testPrivate();
		int errsBefore;
		errsBefore = errCount;
		writeReg(16'hFE30, 8'h4C);
		checkWindow(8'h40, 16'h8000, 16'h83FF, 16'h8400, 16'hBFFF);
		checkWindow(8'h20, 16'h8000, 16'h8FFF, 16'h9000, 16'hBFFF);
		checkWindow(8'h10, 16'h9000, 16'hAFFF, 16'hB000, 16'hBFFF);
		writeReg(16'hFE34, 8'h00);
		writeReg(16'hFE30, 8'h00);
		reportTest("private RAM", errsBefore);
	endtask

	task automatic testRtcBuffer();
		int errsBefore;
		errsBefore = errCount;
		applyCycle(withAlias(16'hFE38), 1'b0, dataT'(takeBits(8)), 1'b0);
		checkBit("rtcAs", rtcAs, 1'b1);
		checkBit("rtcDs", rtcDs, 1'b0);
		checkBit("nDBufCe", nDBufCe, 1'b0);
		// the address strobe only fires on writes
		applyCycle(withAlias(16'hFE38), 1'b1, 8'h00, 1'b0);
		checkBit("rtcAs", rtcAs, 1'b0);
		applyCycle(withAlias(16'hFE3C), 1'b1, 8'h00, 1'b0);
		checkBit("rtcDs", rtcDs, 1'b1);
		checkBit("rtcAs", rtcAs, 1'b0);
		checkBit("nDBufCe", nDBufCe, 1'b0);
		applyCycle(withAlias(16'hFE30), 1'b1, 8'h00, 1'b0);
		checkBit("nDBufCe", nDBufCe, 1'b0);
		beebRomSel = 4'hF;
		writeReg(16'hFE30, 8'h02);
		applyCycle(randIn(16'h8000, 16'hBFFF), 1'b1, 8'h00, 1'b0);
		checkBit("nDBufCe", nDBufCe, 1'b1);
		checkBit("nRomBankSel0to3", nRomBankSel0to3, 1'b0);
		beebRomSel = 4'h0;
		applyCycle(randIn(16'h8000, 16'hBFFF), 1'b1, 8'h00, 1'b0);
		checkBit("nDBufCe", nDBufCe, 1'b0);
		checkBit("nRomBankSel0to3", nRomBankSel0to3, 1'b1);
		writeReg(16'hFE30, 8'h00);
		reportTest("RTC and buffer", errsBefore);
	endtask

	initial begin
		address = '0;
		rnw = 1'b1;
		data = '0;
		phi1 = 1'b0;
		writeProt = takeBits(16);
		beebRomSel = beebSelT'(takeBits(4));
		waitResetRelease(resetReleased);
		if (!resetReleased) begin
			abortRun("reset was never released");
		end else begin
			testReset();
			testBankPaging();
			testShadow();
			testPrivate();
			testRtcBuffer();
			$display("tests run %0d, tests failed %0d, checks failed %0d",
				testCount, failedTests, errCount);
			if (errCount == 0) begin
				$display("Simulation passed");
			end else begin
				$display("Simulation failed");
			end
			$finish;
		end
	end

	// the whole run takes a few microseconds
	initial begin
		#50us;
		abortRun("timeout, the tests did not complete");
	end

endmodule

// File: integraB.f
+incdir+logic
logic/ibPkg.sv
logic/ibInterfaces.sv
logic/pagingRegs.sv
logic/memoryMapDecoder.sv
logic/romBankDecoder.sv
logic/integraB.sv
verif/ibClockGen.sv
verif/integraBTb.sv

// File: runSim.sh
#!/bin/sh
# compile the integraB testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -Mdir obj_dir --top-module integraBTb -f integraB.f
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

output=$(./obj_dir/VintegraBTb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulator exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "Simulation passed"; then
	exit 0
fi
exit 1
